/* hw/pipe_pkg.sv */
package pipe_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [31:0] inst_t;

    // Default data memory depth in words
    localparam int DMEM_WORDS = 16;

    // Immediate formats
    // U type stays at 2 for the operand A register test
    typedef enum logic [2:0] {
        IMM_I    = 3'd0,
        IMM_S    = 3'd1,
        IMM_U    = 3'd2,
        IMM_NONE = 3'd3
    } imm_sel_t;

    // Result source, load code 3
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd3
    } wb_sel_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_PASSB
    } alu_op_t;

    // Major opcodes of the supported set
    localparam opcode_t OPC_LUI   = 7'h37;
    localparam opcode_t OPC_OPIMM = 7'h13;
    localparam opcode_t OPC_OP    = 7'h33;
    localparam opcode_t OPC_LOAD  = 7'h03;
    localparam opcode_t OPC_STORE = 7'h23;

    // Decoder output, also the ID/EXE control payload
    typedef struct packed {
        reg_idx_t rs_a;
        reg_idx_t rs_b;
        reg_idx_t rd;
        logic     wr_en;
        // Operand A from a register
        logic     sel_op_a;
        // Operand B from the immediate
        logic     sel_op_b;
        logic     is_stype;
        imm_sel_t imm_sel;
        xlen_t    imm;
        wb_sel_t  wb_sel;
        alu_op_t  alu_op;
        opcode_t  opcode;
    } dec_t;

    // Retire record, also used for the EXE/MEM and MEM/WB registers
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     wr_en;
        xlen_t    data;
        logic     mem_wr;
        xlen_t    mem_addr;
        xlen_t    mem_wdata;
    } retire_t;

endpackage

/* hw/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
    input  pipe_pkg::inst_t instr,
    output pipe_pkg::dec_t  dec
);

    logic [2:0] funct3;
    logic       funct7_b5;

    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    always_comb begin
        // Defaults describe a bubble
        dec         = '0;
        dec.rs_a    = instr[19:15];
        dec.rs_b    = instr[24:20];
        dec.rd      = instr[11:7];
        dec.opcode  = instr[6:0];
        dec.imm_sel = pipe_pkg::IMM_NONE;
        dec.wb_sel  = pipe_pkg::WB_ALU;
        dec.alu_op  = pipe_pkg::ALU_ADD;

        case (dec.opcode)
            pipe_pkg::OPC_LUI: begin
                // Immediate passed through the ALU
                dec.wr_en    = 1'b1;
                dec.sel_op_b = 1'b1;
                dec.imm_sel  = pipe_pkg::IMM_U;
                dec.alu_op   = pipe_pkg::ALU_PASSB;
            end
            pipe_pkg::OPC_OPIMM: begin
                // ADDI and XORI only
                if (funct3 == 3'b000 || funct3 == 3'b100) begin
                    dec.wr_en    = 1'b1;
                    dec.sel_op_a = 1'b1;
                    dec.sel_op_b = 1'b1;
                    dec.imm_sel  = pipe_pkg::IMM_I;
                    dec.alu_op   = (funct3 == 3'b100) ? pipe_pkg::ALU_XOR : pipe_pkg::ALU_ADD;
                end
            end
            pipe_pkg::OPC_OP: begin
                if (funct3 == 3'b000) begin
                    dec.wr_en    = 1'b1;
                    dec.sel_op_a = 1'b1;
                    dec.alu_op   = funct7_b5 ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
                end else if (funct3 == 3'b100 && !funct7_b5) begin
                    dec.wr_en    = 1'b1;
                    dec.sel_op_a = 1'b1;
                    dec.alu_op   = pipe_pkg::ALU_XOR;
                end
            end
            pipe_pkg::OPC_LOAD: begin
                // Word loads only
                if (funct3 == 3'b010) begin
                    dec.wr_en    = 1'b1;
                    dec.sel_op_a = 1'b1;
                    dec.sel_op_b = 1'b1;
                    dec.imm_sel  = pipe_pkg::IMM_I;
                    dec.wb_sel   = pipe_pkg::WB_MEM;
                end
            end
            pipe_pkg::OPC_STORE: begin
                // rs_b still read as store data
                if (funct3 == 3'b010) begin
                    dec.sel_op_a = 1'b1;
                    dec.sel_op_b = 1'b1;
                    dec.is_stype = 1'b1;
                    dec.imm_sel  = pipe_pkg::IMM_S;
                end
            end
            default: ;
        endcase

        // Sign extended I and S, upper U
        case (dec.imm_sel)
            pipe_pkg::IMM_I: dec.imm = {{20{instr[31]}}, instr[31:20]};
            pipe_pkg::IMM_S: dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            pipe_pkg::IMM_U: dec.imm = {instr[31:12], 12'h000};
            default:         dec.imm = '0;
        endcase
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  pipe_pkg::reg_idx_t rs_a,
    input  pipe_pkg::reg_idx_t rs_b,
    output pipe_pkg::xlen_t    rd_a,
    output pipe_pkg::xlen_t    rd_b,
    input  logic               wr_en,
    input  pipe_pkg::reg_idx_t wr_idx,
    input  pipe_pkg::xlen_t    wr_data
);

    pipe_pkg::xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            // x0 never written
            regs[wr_idx] <= wr_data;
        end
    end

    // Combinational reads, x0 forced to zero
    // No write-through here
    assign rd_a = (rs_a == '0) ? '0 : regs[rs_a];
    assign rd_b = (rs_b == '0) ? '0 : regs[rs_b];

endmodule

/* hw/forwarding_unit.sv */
`timescale 1ns/100ps

module forwarding_unit (
    input  pipe_pkg::reg_idx_t id_rs_a,
    input  pipe_pkg::reg_idx_t id_rs_b,
    input  pipe_pkg::reg_idx_t exe_rs_a,
    input  pipe_pkg::reg_idx_t exe_rs_b,
    input  pipe_pkg::reg_idx_t exe_rd,
    input  pipe_pkg::reg_idx_t mem_rd,
    input  pipe_pkg::reg_idx_t wb_rd,
    input  logic               exe_wr_en,
    input  logic               mem_wr_en,
    input  logic               wb_wr_en,
    input  logic               id_sel_op_a,
    input  logic               id_sel_op_b,
    input  logic               id_is_stype,
    input  pipe_pkg::wb_sel_t  exe_sel_data,
    input  pipe_pkg::wb_sel_t  mem_sel_data,
    input  pipe_pkg::wb_sel_t  wb_sel_data,
    input  pipe_pkg::imm_sel_t id_imm_select,
    input  pipe_pkg::opcode_t  exe_opcode,
    output logic               fw_exe_to_id_a,
    output logic               fw_exe_to_id_b,
    output logic               fw_mem_to_id_a,
    output logic               fw_mem_to_id_b,
    output logic               fw_wb_to_id_a,
    output logic               fw_wb_to_id_b,
    output logic               fw_mem_to_exe_a,
    output logic               fw_mem_to_exe_b,
    output logic               fw_wb_to_exe_a,
    output logic               fw_wb_to_exe_b
);

    logic id_use_a;
    logic id_use_b;
    logic exe_use_a;
    logic exe_use_b;
    logic exe_is_load;
    logic mem_is_load;
    logic wb_is_load;

    // Source matches a live destination, x0 never matches
    function automatic logic hit(
        input pipe_pkg::reg_idx_t src,
        input pipe_pkg::reg_idx_t dst,
        input logic               wr_en
    );
        return (src == dst) && (src != '0) && wr_en;
    endfunction

    // ID consumer reads A as a register, U type never does
    assign id_use_a = id_sel_op_a && (id_imm_select != pipe_pkg::IMM_U);
    // B read as ALU operand or as store data
    assign id_use_b = !id_sel_op_b || id_is_stype;

    // EXE consumer usage from the opcode
    assign exe_use_a = exe_opcode != pipe_pkg::OPC_LUI;
    assign exe_use_b = (exe_opcode == pipe_pkg::OPC_OP) || (exe_opcode == pipe_pkg::OPC_STORE);

    assign exe_is_load = exe_sel_data == pipe_pkg::WB_MEM;
    assign mem_is_load = mem_sel_data == pipe_pkg::WB_MEM;
    assign wb_is_load  = wb_sel_data == pipe_pkg::WB_MEM;

    // Into ID, load data in EXE not ready yet
    assign fw_exe_to_id_a = hit(id_rs_a, exe_rd, exe_wr_en) && !exe_is_load && id_use_a;
    assign fw_exe_to_id_b = hit(id_rs_b, exe_rd, exe_wr_en) && !exe_is_load && id_use_b;
    assign fw_mem_to_id_a = hit(id_rs_a, mem_rd, mem_wr_en) && id_use_a;
    assign fw_mem_to_id_b = hit(id_rs_b, mem_rd, mem_wr_en) && id_use_b;
    assign fw_wb_to_id_a  = hit(id_rs_a, wb_rd, wb_wr_en) && id_use_a;
    assign fw_wb_to_id_b  = hit(id_rs_b, wb_rd, wb_wr_en) && id_use_b;

    // Into EXE, load results only
    assign fw_mem_to_exe_a = hit(exe_rs_a, mem_rd, mem_wr_en) && mem_is_load && exe_use_a;
    assign fw_mem_to_exe_b = hit(exe_rs_b, mem_rd, mem_wr_en) && mem_is_load && exe_use_b;

    // A newer write sitting in MEM was already forwarded at ID
    // so the older WB load must not override it
    assign fw_wb_to_exe_a = hit(exe_rs_a, wb_rd, wb_wr_en) && wb_is_load && exe_use_a &&
                            !hit(exe_rs_a, mem_rd, mem_wr_en);
    assign fw_wb_to_exe_b = hit(exe_rs_b, wb_rd, wb_wr_en) && wb_is_load && exe_use_b &&
                            !hit(exe_rs_b, mem_rd, mem_wr_en);

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
    input  pipe_pkg::alu_op_t op,
    input  pipe_pkg::xlen_t   a,
    input  pipe_pkg::xlen_t   b,
    output pipe_pkg::xlen_t   y
);

    always_comb begin
        case (op)
            pipe_pkg::ALU_ADD: y = a + b;
            pipe_pkg::ALU_SUB: y = a - b;
            pipe_pkg::ALU_XOR: y = a ^ b;
            // LUI, immediate straight through
            default:           y = b;
        endcase
    end

endmodule

/* hw/data_mem.sv */
`timescale 1ns/100ps

module data_mem #(
    parameter int DMEM_WORDS = pipe_pkg::DMEM_WORDS
) (
    input  logic            clk,
    input  logic            rst,
    input  pipe_pkg::xlen_t addr,
    input  logic            wr_en,
    input  pipe_pkg::xlen_t wdata,
    output pipe_pkg::xlen_t rdata
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    pipe_pkg::xlen_t  mem [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // Word index from address bits 5:2 wrapped to the depth
    assign word_idx = IDX_W'(int'(addr[5:2]) % DMEM_WORDS);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[word_idx] <= wdata;
        end
    end

    // Read in the same cycle as the address
    assign rdata = mem[word_idx];

endmodule

/* hw/int_pipeline.sv */
`timescale 1ns/100ps

module int_pipeline #(
    parameter int DMEM_WORDS = pipe_pkg::DMEM_WORDS
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  pipe_pkg::inst_t   instr,
    output pipe_pkg::retire_t retire
);

    // ID stage
    pipe_pkg::dec_t    dec_raw;
    pipe_pkg::dec_t    id_dec;
    pipe_pkg::xlen_t   rf_a;
    pipe_pkg::xlen_t   rf_b;
    pipe_pkg::xlen_t   id_op_a;
    pipe_pkg::xlen_t   id_op_b;

    // ID/EXE register and EXE stage
    logic              ex_valid_q;
    pipe_pkg::dec_t    ex_dec_q;
    pipe_pkg::xlen_t   ex_op_a_q;
    pipe_pkg::xlen_t   ex_op_b_q;
    pipe_pkg::xlen_t   exe_a;
    pipe_pkg::xlen_t   exe_b;
    pipe_pkg::xlen_t   alu_b;
    pipe_pkg::xlen_t   alu_y;
    pipe_pkg::retire_t mem_d;

    // EXE/MEM register and MEM stage
    pipe_pkg::retire_t mem_q;
    pipe_pkg::wb_sel_t mem_sel_q;
    pipe_pkg::xlen_t   dmem_rdata;
    pipe_pkg::retire_t wb_d;

    // MEM/WB register
    pipe_pkg::retire_t wb_q;
    pipe_pkg::wb_sel_t wb_sel_q;

    // Forward selects
    logic fw_exe_to_id_a;
    logic fw_exe_to_id_b;
    logic fw_mem_to_id_a;
    logic fw_mem_to_id_b;
    logic fw_wb_to_id_a;
    logic fw_wb_to_id_b;
    logic fw_mem_to_exe_a;
    logic fw_mem_to_exe_b;
    logic fw_wb_to_exe_a;
    logic fw_wb_to_exe_b;

    // ID operand priority EXE, MEM, WB, register file
    function automatic pipe_pkg::xlen_t fwd_id(
        input logic            use_exe,
        input logic            use_mem,
        input logic            use_wb,
        input pipe_pkg::xlen_t v_exe,
        input pipe_pkg::xlen_t v_mem,
        input pipe_pkg::xlen_t v_wb,
        input pipe_pkg::xlen_t v_rf
    );
        return use_exe ? v_exe : use_mem ? v_mem : use_wb ? v_wb : v_rf;
    endfunction

    // EXE operand, MEM load data ahead of WB load data
    function automatic pipe_pkg::xlen_t fwd_exe(
        input logic            use_mem,
        input logic            use_wb,
        input pipe_pkg::xlen_t v_mem,
        input pipe_pkg::xlen_t v_wb,
        input pipe_pkg::xlen_t v_latched
    );
        return use_mem ? v_mem : use_wb ? v_wb : v_latched;
    endfunction

    // Control bits of a stage record cleared on reset
    function automatic pipe_pkg::retire_t clear_ctrl(
        input pipe_pkg::retire_t r,
        input logic              clr
    );
        pipe_pkg::retire_t o;
        o = r;
        if (clr) begin
            o.valid  = 1'b0;
            o.wr_en  = 1'b0;
            o.mem_wr = 1'b0;
        end
        return o;
    endfunction

    inst_decoder u_inst_decoder (
        .instr (instr),
        .dec   (dec_raw)
    );

    // Bubble enters with every field zero
    assign id_dec = in_valid ? dec_raw : pipe_pkg::dec_t'('0);

    // WB writes land at the edge, WB to ID forward covers the gap
    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs_a    (id_dec.rs_a),
        .rs_b    (id_dec.rs_b),
        .rd_a    (rf_a),
        .rd_b    (rf_b),
        .wr_en   (wb_q.wr_en),
        .wr_idx  (wb_q.rd),
        .wr_data (wb_q.data)
    );

    forwarding_unit u_forwarding_unit (
        .id_rs_a         (id_dec.rs_a),
        .id_rs_b         (id_dec.rs_b),
        .exe_rs_a        (ex_dec_q.rs_a),
        .exe_rs_b        (ex_dec_q.rs_b),
        .exe_rd          (ex_dec_q.rd),
        .mem_rd          (mem_q.rd),
        .wb_rd           (wb_q.rd),
        .exe_wr_en       (ex_dec_q.wr_en),
        .mem_wr_en       (mem_q.wr_en),
        .wb_wr_en        (wb_q.wr_en),
        .id_sel_op_a     (id_dec.sel_op_a),
        .id_sel_op_b     (id_dec.sel_op_b),
        .id_is_stype     (id_dec.is_stype),
        .exe_sel_data    (ex_dec_q.wb_sel),
        .mem_sel_data    (mem_sel_q),
        .wb_sel_data     (wb_sel_q),
        .id_imm_select   (id_dec.imm_sel),
        .exe_opcode      (ex_dec_q.opcode),
        .fw_exe_to_id_a  (fw_exe_to_id_a),
        .fw_exe_to_id_b  (fw_exe_to_id_b),
        .fw_mem_to_id_a  (fw_mem_to_id_a),
        .fw_mem_to_id_b  (fw_mem_to_id_b),
        .fw_wb_to_id_a   (fw_wb_to_id_a),
        .fw_wb_to_id_b   (fw_wb_to_id_b),
        .fw_mem_to_exe_a (fw_mem_to_exe_a),
        .fw_mem_to_exe_b (fw_mem_to_exe_b),
        .fw_wb_to_exe_a  (fw_wb_to_exe_a),
        .fw_wb_to_exe_b  (fw_wb_to_exe_b)
    );

    // MEM forward carries the ALU result
    // A MEM-stage load is fixed up later by the WB to EXE path
    assign id_op_a = fwd_id(fw_exe_to_id_a, fw_mem_to_id_a, fw_wb_to_id_a,
                            alu_y, mem_q.data, wb_q.data, rf_a);
    assign id_op_b = fwd_id(fw_exe_to_id_b, fw_mem_to_id_b, fw_wb_to_id_b,
                            alu_y, mem_q.data, wb_q.data, rf_b);

    always_ff @(posedge clk) begin
        ex_valid_q <= in_valid;
        ex_dec_q   <= id_dec;
        ex_op_a_q  <= id_op_a;
        ex_op_b_q  <= id_op_b;
        if (rst) begin
            ex_valid_q        <= 1'b0;
            ex_dec_q.wr_en    <= 1'b0;
            ex_dec_q.is_stype <= 1'b0;
        end
    end

    // Load data overrides what was latched at ID
    assign exe_a = fwd_exe(fw_mem_to_exe_a, fw_wb_to_exe_a, dmem_rdata, wb_q.data, ex_op_a_q);
    assign exe_b = fwd_exe(fw_mem_to_exe_b, fw_wb_to_exe_b, dmem_rdata, wb_q.data, ex_op_b_q);

    // Immediate replaces B, store data keeps the register value
    assign alu_b = ex_dec_q.sel_op_b ? ex_dec_q.imm : exe_b;

    alu u_alu (
        .op (ex_dec_q.alu_op),
        .a  (exe_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_comb begin
        mem_d.valid     = ex_valid_q;
        mem_d.rd        = ex_dec_q.rd;
        mem_d.wr_en     = ex_dec_q.wr_en;
        // ALU result, also the memory address
        mem_d.data      = alu_y;
        mem_d.mem_wr    = ex_dec_q.is_stype;
        mem_d.mem_addr  = ex_dec_q.is_stype ? alu_y : '0;
        mem_d.mem_wdata = ex_dec_q.is_stype ? exe_b : '0;
    end

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .clk   (clk),
        .rst   (rst),
        .addr  (mem_q.data),
        .wr_en (mem_q.mem_wr),
        .wdata (mem_q.mem_wdata),
        .rdata (dmem_rdata)
    );

    // Result selected for writeback, zero when nothing is written
    always_comb begin
        wb_d = mem_q;
        if (!mem_q.wr_en) begin
            wb_d.data = '0;
        end else if (mem_sel_q == pipe_pkg::WB_MEM) begin
            wb_d.data = dmem_rdata;
        end
    end

    // EXE/MEM, MEM/WB and retire registers
    always_ff @(posedge clk) begin
        mem_q     <= clear_ctrl(mem_d, rst);
        mem_sel_q <= ex_dec_q.wb_sel;
        wb_q      <= clear_ctrl(wb_d, rst);
        wb_sel_q  <= mem_sel_q;
        retire    <= clear_ctrl(wb_q, rst);
    end

endmodule

/* testbench/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // Free running, low at time zero
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

/* testbench/int_pipeline_props.sv */
`timescale 1ns/100ps

module int_pipeline_props (
    input logic              clk,
    input logic              rst,
    input logic              in_valid,
    input pipe_pkg::retire_t retire
);

    // Failure tallies, read back by the testbench top
    int unsigned reset_fail_count     = 0;
    int unsigned valid_lag_fail_count = 0;
    int unsigned bubble_fail_count    = 0;
    int unsigned excl_fail_count      = 0;

    // Quiet retire port in reset and one cycle beyond
    retire_quiet_in_reset: assert property (
        @(posedge clk) (rst || $past(rst)) |=> !retire.valid
    ) else begin
        reset_fail_count++;
        $error("retire.valid set during reset or the cycle after it");
    end

    // Sampled at edge N, seen on retire at edge N+4
    valid_retires_after_three: assert property (
        @(posedge clk) disable iff (rst) in_valid |-> ##4 retire.valid
    ) else begin
        valid_lag_fail_count++;
        $error("valid instruction did not retire three cycles later");
    end

    bubble_retires_invalid: assert property (
        @(posedge clk) disable iff (rst) !in_valid |-> ##4 !retire.valid
    ) else begin
        bubble_fail_count++;
        $error("bubble retired with valid set");
    end

    // Register write and store are exclusive
    no_write_and_store: assert property (
        @(posedge clk) disable iff (rst) !(retire.wr_en && retire.mem_wr)
    ) else begin
        excl_fail_count++;
        $error("retire has both wr_en and mem_wr set");
    end

endmodule

/* testbench/tb_int_pipeline.sv */
`timescale 1ns/100ps

module tb_int_pipeline;

    localparam int          CLK_PERIOD_NS = 4;
    localparam int          RESET_CYCLES  = 3;
    localparam int          N_CYCLES      = 2000;
    // Bubbles after the stream to flush the last results out
    localparam int          DRAIN_CYCLES  = 4;
    localparam int          WATCHDOG_NS   = (N_CYCLES + 20) * CLK_PERIOD_NS;
    localparam int          MEM_WORDS     = 16;
    localparam int unsigned SEED          = 32'hecae_d14d;

    logic              clk;
    logic              rst;
    logic              in_valid;
    pipe_pkg::inst_t   instr;
    pipe_pkg::retire_t retire;

    // Architectural model state
    pipe_pkg::xlen_t   arch_regs [32];
    pipe_pkg::xlen_t   arch_mem [MEM_WORDS];
    // Expected retire records, oldest first
    pipe_pkg::retire_t expected_q [$];

    int unsigned error_count;
    int unsigned check_count;
    int unsigned retired_count;
    int unsigned prop_failures;

    clock_gen #(
        .PERIOD_NS (CLK_PERIOD_NS)
    ) u_clock_gen (
        .clk (clk)
    );

    int_pipeline #(
        .DMEM_WORDS (MEM_WORDS)
    ) u_int_pipeline (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .instr    (instr),
        .retire   (retire)
    );

    bind int_pipeline int_pipeline_props u_int_pipeline_props (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .retire   (retire)
    );

    // RV32 encodings
    function automatic pipe_pkg::inst_t r_type_word(
        input logic [6:0]         funct7,
        input pipe_pkg::reg_idx_t rs2,
        input pipe_pkg::reg_idx_t rs1,
        input logic [2:0]         funct3,
        input pipe_pkg::reg_idx_t rd
    );
        return {funct7, rs2, rs1, funct3, rd, pipe_pkg::OPC_OP};
    endfunction

    function automatic pipe_pkg::inst_t i_type_word(
        input logic [11:0]        imm,
        input pipe_pkg::reg_idx_t rs1,
        input logic [2:0]         funct3,
        input pipe_pkg::reg_idx_t rd,
        input pipe_pkg::opcode_t  opcode
    );
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    // SW only, funct3 fixed at word size
    function automatic pipe_pkg::inst_t s_type_word(
        input logic [11:0]        imm,
        input pipe_pkg::reg_idx_t rs2,
        input pipe_pkg::reg_idx_t rs1
    );
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], pipe_pkg::OPC_STORE};
    endfunction

    function automatic pipe_pkg::inst_t u_type_word(
        input logic [19:0]        imm,
        input pipe_pkg::reg_idx_t rd
    );
        return {imm, rd, pipe_pkg::OPC_LUI};
    endfunction

    // Pick one instruction, run it on the model, return its retire record
    task automatic make_instruction(
        output pipe_pkg::inst_t   word,
        output pipe_pkg::retire_t want
    );
        int unsigned        kind;
        pipe_pkg::reg_idx_t rs1;
        pipe_pkg::reg_idx_t rs2;
        pipe_pkg::reg_idx_t rd;
        logic [7:0]         imm8;
        logic [11:0]        imm12;
        logic [19:0]        imm20;
        logic [3:0]         widx;
        pipe_pkg::xlen_t    simm;
        pipe_pkg::xlen_t    result;

        kind = $urandom_range(0, 7);
        // x0 to x7 only, so hazards are frequent
        rs1 = 5'($urandom_range(0, 7));
        rs2 = 5'($urandom_range(0, 7));
        rd = 5'($urandom_range(0, 7));
        imm8 = 8'($urandom);
        imm12 = {{4{imm8[7]}}, imm8};
        imm20 = 20'($urandom);
        widx = 4'($urandom_range(0, MEM_WORDS - 1));
        simm = {{20{imm12[11]}}, imm12};
        result = '0;
        want = '0;
        want.valid = 1'b1;

        case (kind)
            0: begin
                // LUI, rs_a field is just immediate bits
                word = u_type_word(imm20, rd);
                result = {imm20, 12'h000};
            end
            1: begin
                word = i_type_word(imm12, rs1, 3'b000, rd, pipe_pkg::OPC_OPIMM);
                result = arch_regs[rs1] + simm;
            end
            2: begin
                word = i_type_word(imm12, rs1, 3'b100, rd, pipe_pkg::OPC_OPIMM);
                result = arch_regs[rs1] ^ simm;
            end
            3: begin
                word = r_type_word(7'h00, rs2, rs1, 3'b000, rd);
                result = arch_regs[rs1] + arch_regs[rs2];
            end
            4: begin
                word = r_type_word(7'h20, rs2, rs1, 3'b000, rd);
                result = arch_regs[rs1] - arch_regs[rs2];
            end
            5: begin
                word = r_type_word(7'h00, rs2, rs1, 3'b100, rd);
                result = arch_regs[rs1] ^ arch_regs[rs2];
            end
            6: begin
                // LW from x0 plus a word offset
                word = i_type_word({6'd0, widx, 2'b00}, 5'd0, 3'b010, rd, pipe_pkg::OPC_LOAD);
                result = arch_mem[widx];
            end
            default: begin
                word = s_type_word({6'd0, widx, 2'b00}, rs2, 5'd0);
                want.mem_wr = 1'b1;
                want.mem_addr = {26'd0, widx, 2'b00};
                want.mem_wdata = arch_regs[rs2];
                arch_mem[widx] = arch_regs[rs2];
            end
        endcase

        // Everything but SW writes a register, x0 stays zero
        if (kind != 7) begin
            want.wr_en = 1'b1;
            want.rd = rd;
            want.data = result;
            if (rd != 5'd0) begin
                arch_regs[rd] = result;
            end
        end
    endtask

    task automatic report_mismatch(
        input string           field,
        input pipe_pkg::xlen_t got,
        input pipe_pkg::xlen_t want
    );
        error_count++;
        $display("FAIL t=%0t: retire.%s is 0x%08h, expected 0x%08h", $time, field, got, want);
    endtask

    // Bubbles only need quiet control bits
    task automatic compare_retire(
        input pipe_pkg::retire_t got,
        input pipe_pkg::retire_t want
    );
        check_count++;
        assert (got.valid == want.valid)
            else report_mismatch("valid", 32'(got.valid), 32'(want.valid));
        assert (got.wr_en == want.wr_en)
            else report_mismatch("wr_en", 32'(got.wr_en), 32'(want.wr_en));
        assert (got.mem_wr == want.mem_wr)
            else report_mismatch("mem_wr", 32'(got.mem_wr), 32'(want.mem_wr));
        if (want.valid) begin
            retired_count++;
            // Destination only means something for a register write
            if (want.wr_en) begin
                assert (got.rd == want.rd)
                    else report_mismatch("rd", 32'(got.rd), 32'(want.rd));
            end
            assert (got.data == want.data)
                else report_mismatch("data", got.data, want.data);
            assert (got.mem_addr == want.mem_addr)
                else report_mismatch("mem_addr", got.mem_addr, want.mem_addr);
            assert (got.mem_wdata == want.mem_wdata)
                else report_mismatch("mem_wdata", got.mem_wdata, want.mem_wdata);
        end
    endtask

    initial begin
        pipe_pkg::inst_t   word;
        pipe_pkg::retire_t want;

        rst = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        error_count = 0;
        check_count = 0;
        retired_count = 0;
        prop_failures = 0;
        void'($urandom(SEED));
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            arch_mem[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Pipeline holds four cleared records on the way out
        repeat (4) expected_q.push_back(pipe_pkg::retire_t'('0));

        for (int cyc = 0; cyc < N_CYCLES + DRAIN_CYCLES; cyc++) begin
            compare_retire(retire, expected_q.pop_front());
            if (cyc < N_CYCLES && $urandom_range(0, 99) < 85) begin
                make_instruction(word, want);
                in_valid = 1'b1;
                instr = word;
            end else begin
                // Bubble with junk on instr
                in_valid = 1'b0;
                instr = 32'($urandom);
                want = '0;
            end
            expected_q.push_back(want);
            @(negedge clk);
        end

        prop_failures = u_int_pipeline.u_int_pipeline_props.reset_fail_count
                      + u_int_pipeline.u_int_pipeline_props.valid_lag_fail_count
                      + u_int_pipeline.u_int_pipeline_props.bubble_fail_count
                      + u_int_pipeline.u_int_pipeline_props.excl_fail_count;
        $display("checks %0d, retired %0d, mismatches %0d, property failures %0d",
                 check_count, retired_count, error_count, prop_failures);
        if (error_count == 0 && prop_failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Stream length plus a margin
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog.f */
hw/pipe_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/forwarding_unit.sv
hw/alu.sv
hw/data_mem.sv
hw/int_pipeline.sv
testbench/clock_gen.sv
testbench/int_pipeline_props.sv
testbench/tb_int_pipeline.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the int_pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_int_pipeline \
        -Mdir obj_dir -f verilog.f; then
    echo "Verilator build failed"
    exit 1
fi

# Keep going after an assertion error so the testbench can report it
output=$(./obj_dir/Vtb_int_pipeline +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
